/* elapsed_timer.sv */
`timescale 1ns/1ns

module elapsed_timer (
    input  logic        clk_gui,
    input  logic        timer_reset,
    input  logic        clear,       // one cycle restart from status_regs
    output logic [15:0] mins_bcd,    // four bcd digits
    output logic [15:0] secs         // binary, free wrap at 16 bits
);

    logic [31:0] sec_tick;  // cycles inside current second
    logic [31:0] min_tick;  // cycles inside current minute
    logic        restart;

    assign restart = timer_reset | clear;

    // add one to a four digit bcd value, 9999 wraps to 0000
    function automatic logic [15:0] bcd_inc(input logic [15:0] value);
        logic [15:0] result;
        logic        carry;
        result = value;
        carry  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (carry) begin
                if (result[i*4 +: 4] == 4'd9) begin
                    result[i*4 +: 4] = 4'd0;  // digit rolls, carry moves up
                end else begin
                    result[i*4 +: 4] = result[i*4 +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // seconds
    //////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (restart) begin
            sec_tick <= '0;
            secs     <= '0;
        end else if (sec_tick == mem_status_pkg::TICKS_PER_SEC - 32'd1) begin
            sec_tick <= '0;
            secs     <= secs + 16'd1; // no limit, wraps
        end else begin
            sec_tick <= sec_tick + 32'd1;
        end
    end

    //////////////////////////////////////////////////
    // minutes, own tick counter
    //////////////////////////////////////////////////

    // separate count rather than derived from secs
    always_ff @(posedge clk_gui) begin
        if (restart) begin
            min_tick <= '0;
            mins_bcd <= '0;
        end else if (min_tick == mem_status_pkg::TICKS_PER_MIN - 32'd1) begin
            min_tick <= '0;
            mins_bcd <= bcd_inc(mins_bcd);
        end else begin
            min_tick <= min_tick + 32'd1;
        end
    end

    // carry chain must keep every digit decimal
    a_bcd_digits: assert property (@(posedge clk_gui) disable iff (timer_reset)
        (mins_bcd[3:0] <= 4'd9) && (mins_bcd[7:4] <= 4'd9) &&
        (mins_bcd[11:8] <= 4'd9) && (mins_bcd[15:12] <= 4'd9))
        else $error("mins_bcd digit out of range %h", mins_bcd);

endmodule

/* mem_status.f */
mem_status_pkg.sv
tally_if.sv
elapsed_timer.sv
result_tally.sv
status_regs.sv
mem_status_top.sv
tb_mem_status.sv

/* mem_status_pkg.sv */
package mem_status_pkg;

    //////////////////////////////////////////////////
    // timing constants
    //////////////////////////////////////////////////

    // clk_gui cycles per second, kept small for short runs
    localparam logic [31:0] TICKS_PER_SEC = 32'd25;
    localparam logic [31:0] TICKS_PER_MIN = TICKS_PER_SEC * 32'd60; // 1500 cycles

    // tested word address width from the memory tester
    localparam int ADDR_W = 24;

    //////////////////////////////////////////////////
    // apb register map, byte offsets
    //////////////////////////////////////////////////

    localparam logic [4:0] REG_PASS       = 5'h00; // pass count
    localparam logic [4:0] REG_FAIL       = 5'h04; // fail count
    localparam logic [4:0] REG_ELAPSED    = 5'h08; // running time word
    localparam logic [4:0] REG_FIRST_ADDR = 5'h0C; // first failing address
    localparam logic [4:0] REG_FIRST_TIME = 5'h10; // time of first failure
    localparam logic [4:0] REG_CONTROL    = 5'h14; // write only, reads 0

    // control word bit that requests a clear of counts and timer
    localparam int CTRL_CLEAR_BIT = 0;

    //////////////////////////////////////////////////
    // time word
    //////////////////////////////////////////////////

    // field view of the time word
    typedef struct packed {
        logic [15:0] mins_bcd; // four bcd digits, 0000..9999
        logic [15:0] secs;     // plain binary seconds
    } time_fields_t;

    // one 32 bit word read two ways
    // packed by fields inside status_regs, driven onto prdata raw
    typedef union packed {
        logic [31:0]  raw;
        time_fields_t fields;
    } time_word_u;

endpackage

/* mem_status_stimulus.txt */
# columns: C pass addr | W cycles | R offset expected | X value | E offset | F offset value
# pass and cycles in decimal, addr offset expected value in hex
R 00 00000000
W 60
C 1 000100
C 1 000104
C 0 0abcde
C 0 000200
C 1 000108
C 0 000204
C 0 000208
C 0 00020c
C 0 000210
C 1 00010c
C 0 000214
C 0 000218
C 0 00021c
R 00 00000004
R 04 00000009
R 0c 000abcde
R 10 00000002
R 08 00000004
W 1500
R 08 00010040
E 18
F 00 12345678
F 08 00000001
F 1c 00000001
R 00 00000004
R 04 00000009
R 0c 000abcde
R 08 00010041
X 00000001
R 00 00000000
R 04 00000000
R 0c 00000000
R 10 00000000
R 08 00000000
W 90
C 0 00f00d
C 1 000300
C 0 000777
R 0c 0000f00d
R 10 00000004
R 04 00000002
W 15000
R 08 0010025c
R 10 00000004

/* mem_status_top.sv */
`timescale 1ns/1ns

module mem_status_top (
    input  logic                              clk_gui,
    input  logic                              timer_reset,
    // results from the memory tester, already in clk_gui
    input  logic                              check_valid,
    input  logic                              check_pass,
    input  logic [mem_status_pkg::ADDR_W-1:0] check_addr,
    // apb slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [4:0]                        paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    // board leds, fail count mod 8
    output logic [2:0]                        led
);

    logic [15:0] mins_bcd;  // timer to regs
    logic [15:0] secs;
    logic        clear;     // regs to timer and tally

    tally_if tally_bus ();

    //////////////////////////////////////////////////
    // run timer
    //////////////////////////////////////////////////

    elapsed_timer u_timer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .clear       (clear),
        .mins_bcd    (mins_bcd),
        .secs        (secs)
    );

    //////////////////////////////////////////////////
    // pass and fail tally
    //////////////////////////////////////////////////

    result_tally u_tally (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .clear       (clear),
        .check_valid (check_valid),
        .check_pass  (check_pass),
        .check_addr  (check_addr),
        .tally       (tally_bus.source)
    );

    //////////////////////////////////////////////////
    // register file and leds
    //////////////////////////////////////////////////

    status_regs u_regs (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .mins_bcd    (mins_bcd),
        .secs        (secs),
        .tally       (tally_bus.sink),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .clear       (clear),
        .led         (led)
    );

endmodule

/* result_tally.sv */
`timescale 1ns/1ns

module result_tally (
    input  logic                              clk_gui,
    input  logic                              timer_reset,
    input  logic                              clear,        // from control write
    input  logic                              check_valid,  // one result per cycle
    input  logic                              check_pass,   // 1 pass, 0 fail
    input  logic [mem_status_pkg::ADDR_W-1:0] check_addr,   // word under check
    tally_if.source                           tally
);

    logic restart;
    logic pass_hit;
    logic fail_hit;
    logic fail_seen;   // first failure already captured

    assign restart  = timer_reset | clear;
    assign pass_hit = check_valid & check_pass;
    assign fail_hit = check_valid & ~check_pass;

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (restart) begin
            tally.pass_count <= '0;
            tally.fail_count <= '0;
        end else begin
            if (pass_hit) begin
                tally.pass_count <= tally.pass_count + 32'd1;
            end
            if (fail_hit) begin
                tally.fail_count <= tally.fail_count + 32'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // first failure capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (restart) begin
            fail_seen             <= 1'b0;  // armed again
            tally.first_fail      <= 1'b0;
            tally.first_fail_addr <= '0;
        end else begin
            tally.first_fail <= 1'b0;       // pulse only
            if (fail_hit && !fail_seen) begin
                fail_seen             <= 1'b1;
                tally.first_fail      <= 1'b1;
                tally.first_fail_addr <= check_addr;
            end
        end
    end

    // failure count only moves up between clears
    a_fail_monotonic: assert property (@(posedge clk_gui) disable iff (timer_reset)
        (!$past(clear) && !$past(timer_reset)) |->
            (tally.fail_count >= $past(tally.fail_count)))
        else $error("fail_count went down without clear");

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mem_status \
    -f mem_status.f \
    -o sim_mem_status

output=$(./obj_dir/sim_mem_status 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Everything OK"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* status_regs.sv */
`timescale 1ns/1ns

module status_regs (
    input  logic        clk_gui,
    input  logic        timer_reset,
    // timer and tally results
    input  logic [15:0] mins_bcd,
    input  logic [15:0] secs,
    tally_if.sink       tally,
    // apb slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // to timer, tally and board
    output logic        clear,     // one cycle pulse
    output logic [2:0]  led
);

    logic                      access;      // apb access phase
    logic                      addr_ok;     // paddr hits a defined register
    logic                      ctrl_write;  // legal write to control
    mem_status_pkg::time_word_u elapsed_now; // live time word
    mem_status_pkg::time_word_u first_time;  // stamped at first failure

    //////////////////////////////////////////////////
    // apb decode
    //////////////////////////////////////////////////

    assign access = psel & penable;
    assign pready = 1'b1;  // no wait states

    always_comb begin
        case (paddr)
            mem_status_pkg::REG_PASS,
            mem_status_pkg::REG_FAIL,
            mem_status_pkg::REG_ELAPSED,
            mem_status_pkg::REG_FIRST_ADDR,
            mem_status_pkg::REG_FIRST_TIME,
            mem_status_pkg::REG_CONTROL: addr_ok = 1'b1;
            default:                     addr_ok = 1'b0;
        endcase
    end

    // only control is writable
    assign ctrl_write = access & pwrite & (paddr == mem_status_pkg::REG_CONTROL);

    // bad offset, or write to a read only register
    assign pslverr = access & (~addr_ok | (pwrite & ~ctrl_write));

    //////////////////////////////////////////////////
    // time word and first failure stamp
    //////////////////////////////////////////////////

    always_comb begin
        elapsed_now.fields.mins_bcd = mins_bcd;  // high half
        elapsed_now.fields.secs     = secs;      // low half
    end

    always_ff @(posedge clk_gui) begin
        if (timer_reset || clear) begin
            first_time <= '0;
        end else if (tally.first_fail) begin
            first_time <= elapsed_now;  // time one edge after the capture
        end
    end

    //////////////////////////////////////////////////
    // clear generation
    //////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            clear <= 1'b0;
        end else begin
            clear <= ctrl_write & pwdata[mem_status_pkg::CTRL_CLEAR_BIT];
        end
    end

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////

    always_comb begin
        case (paddr)
            mem_status_pkg::REG_PASS:       prdata = tally.pass_count;
            mem_status_pkg::REG_FAIL:       prdata = tally.fail_count;
            mem_status_pkg::REG_ELAPSED:    prdata = elapsed_now.raw;
            mem_status_pkg::REG_FIRST_ADDR: begin
                prdata = {{(32 - mem_status_pkg::ADDR_W){1'b0}}, tally.first_fail_addr};
            end
            mem_status_pkg::REG_FIRST_TIME: prdata = first_time.raw;
            default:                        prdata = '0;  // control and holes
        endcase
    end

    // low failure bits on the board leds
    assign led = tally.fail_count[2:0];

    // clear stays a single cycle pulse between setup phases
    a_clear_pulse: assert property (@(posedge clk_gui) disable iff (timer_reset)
        clear |=> !clear)
        else $error("clear held high for more than one cycle");

endmodule

/* tally_if.sv */
`timescale 1ns/1ns

// tally results from result_tally to status_regs
interface tally_if;

    logic [31:0]                       pass_count;      // valid passes since clear
    logic [31:0]                       fail_count;      // valid failures since clear
    logic [mem_status_pkg::ADDR_W-1:0] first_fail_addr; // held after first failure
    logic                              first_fail;      // one cycle pulse

    // producer side
    modport source (
        output pass_count,
        output fail_count,
        output first_fail_addr,
        output first_fail
    );

    // consumer side, register file
    modport sink (
        input pass_count,
        input fail_count,
        input first_fail_addr,
        input first_fail
    );

endinterface

/* tb_mem_status.sv */
`timescale 1ns/1ns

module tb_mem_status;

    logic                              clk_gui;
    logic                              timer_reset;
    logic                              check_valid;
    logic                              check_pass;
    logic [mem_status_pkg::ADDR_W-1:0] check_addr;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [4:0]                        paddr;
    logic [31:0]                       pwdata;
    logic [31:0]                       prdata;
    logic                              pready;
    logic                              pslverr;
    logic [2:0]                        led;

    int watch_cycles;  // run limit in clock cycles
    bit budget_ready;  // watchdog may start counting

    mem_status_top uut (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .check_valid (check_valid),
        .check_pass  (check_pass),
        .check_addr  (check_addr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .led         (led)
    );

    // 40 ns period
    initial begin
        clk_gui = 1'b0;
        forever #20 clk_gui = ~clk_gui;
    end

    //////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("Error: time %0t ns, %s expected %h, actual %h", $time, name, expected, actual);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("Error: %s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // stimulus file parsing
    //////////////////////////////////////////////////

    // drop the rest of a comment line
    task automatic skip_comment(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    // counts and pass flag are decimal, everything else hex
    task automatic read_args(input int fd, input logic [7:0] cmd,
                             output logic [31:0] a0, output logic [31:0] a1);
        int          code;
        int          want;
        logic [31:0] v0;
        logic [31:0] v1;
        v0   = '0;
        v1   = '0;
        code = 0;
        case (cmd)
            "C": begin
                want = 2;
                code = $fscanf(fd, " %d %h", v0, v1);
            end
            "W": begin
                want = 1;
                code = $fscanf(fd, " %d", v0);
            end
            "R", "F": begin
                want = 2;
                code = $fscanf(fd, " %h %h", v0, v1);
            end
            "X", "E": begin
                want = 1;
                code = $fscanf(fd, " %h", v0);
            end
            default: want = -1;
        endcase
        a0 = v0;
        a1 = v1;
        if (want < 0) begin
            abort_run("unknown command letter in the stimulus file");
        end else if (code != want) begin
            abort_run("stimulus line is missing an argument");
        end
    endtask

    // first pass sums idle counts and four cycles per command, plus slack
    task automatic budget_from_file(output int cycles);
        int          fd;
        int          code;
        bit          done;
        logic [7:0]  cmd;
        logic [31:0] a0;
        logic [31:0] a1;
        cycles = 100;
        done   = 1'b0;
        fd     = $fopen("mem_status_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open mem_status_stimulus.txt");
        end else begin
            while (!done) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) begin
                    done = 1'b1;
                end else if (cmd == "#") begin
                    skip_comment(fd);
                end else begin
                    read_args(fd, cmd, a0, a1);
                    cycles += 4;
                    if (cmd == "W") cycles += int'(a0);
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // bus and result drivers
    //////////////////////////////////////////////////

    task automatic apply_reset();
        timer_reset <= 1'b1;
        repeat (16) @(posedge clk_gui);
        timer_reset <= 1'b0;  // 16th edge is the restart edge
    endtask

    task automatic send_result(input logic result_pass,
                               input logic [mem_status_pkg::ADDR_W-1:0] addr);
        @(posedge clk_gui);
        check_valid <= 1'b1;
        check_pass  <= result_pass;
        check_addr  <= addr;
        @(posedge clk_gui);       // sampled by the tally here
        check_valid <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_gui);
    endtask

    task automatic setup_phase(input logic [4:0] off, input logic write,
                               input logic [31:0] data);
        @(posedge clk_gui);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= off;
        pwdata  <= data;
    endtask

    // access phase and a settle to mid cycle for sampling
    task automatic access_phase();
        @(posedge clk_gui);
        penable <= 1'b1;
        @(negedge clk_gui);
        assert (pready == 1'b1) else flag_mismatch("pready", 32'd1, {31'd0, pready});
    endtask

    task automatic end_transfer();
        @(posedge clk_gui);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_read(input logic [4:0] off, input logic [31:0] expected);
        setup_phase(off, 1'b0, 32'd0);
        access_phase();
        assert (pslverr == 1'b0) else flag_mismatch("pslverr", 32'd0, {31'd0, pslverr});
        assert (prdata == expected) else flag_mismatch("prdata", expected, prdata);
        if (off == mem_status_pkg::REG_FAIL) begin  // leds follow fail count mod 8
            assert (led == expected[2:0])
                else flag_mismatch("led", {29'd0, expected[2:0]}, {29'd0, led});
        end
        end_transfer();
    endtask

    task automatic rejected_read(input logic [4:0] off);
        setup_phase(off, 1'b0, 32'd0);
        access_phase();
        assert (pslverr == 1'b1) else flag_mismatch("pslverr", 32'd1, {31'd0, pslverr});
        end_transfer();
    endtask

    task automatic bad_write(input logic [4:0] off, input logic [31:0] data);
        setup_phase(off, 1'b1, data);
        access_phase();
        assert (pslverr == 1'b1) else flag_mismatch("pslverr", 32'd1, {31'd0, pslverr});
        end_transfer();
    endtask

    // wait out the edge where clear lands
    task automatic control_write(input logic [31:0] data);
        setup_phase(mem_status_pkg::REG_CONTROL, 1'b1, data);
        access_phase();
        assert (pslverr == 1'b0) else flag_mismatch("pslverr", 32'd0, {31'd0, pslverr});
        end_transfer();
        @(posedge clk_gui);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          code;
        bit          done;
        logic [7:0]  cmd;
        logic [31:0] a0;
        logic [31:0] a1;
        timer_reset  <= 1'b1;
        check_valid  <= 1'b0;
        check_pass   <= 1'b0;
        check_addr   <= '0;
        psel         <= 1'b0;
        penable      <= 1'b0;
        pwrite       <= 1'b0;
        paddr        <= '0;
        pwdata       <= '0;
        budget_ready = 1'b0;
        done         = 1'b0;
        budget_from_file(watch_cycles);
        budget_ready = 1'b1;
        apply_reset();
        fd = $fopen("mem_status_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open mem_status_stimulus.txt");
        end else begin
            while (!done) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) begin
                    done = 1'b1;  // end of file
                end else if (cmd == "#") begin
                    skip_comment(fd);
                end else begin
                    read_args(fd, cmd, a0, a1);
                    case (cmd)
                        "C":     send_result(a0[0], a1[mem_status_pkg::ADDR_W-1:0]);
                        "W":     idle_cycles(int'(a0));
                        "R":     check_read(a0[4:0], a1);
                        "X":     control_write(a0);
                        "E":     rejected_read(a0[4:0]);
                        "F":     bad_write(a0[4:0], a1);
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
            $display("Everything OK");
            $finish;
        end
    end

    // watchdog limit taken from the stimulus length
    initial begin
        wait (budget_ready);
        #(watch_cycles * 40);
        abort_run("watchdog timeout, the stimulus did not finish in time");
    end

endmodule
